// ==== design/bank_tracker.sv ====
`timescale 1ns/1ns

module bank_tracker (
    input  logic                    clk,
    input  logic                    rst,
    input  sdram_pkg::bank_t        lookup_bank,
    input  sdram_pkg::row_t         lookup_row,
    output sdram_pkg::bank_state_e  bank_state,
    input  logic                    open_en,
    input  sdram_pkg::bank_t        open_bank,
    input  sdram_pkg::row_t         open_row,
    input  logic                    close_en,
    input  logic                    close_all,
    input  sdram_pkg::bank_t        close_bank
);
    import sdram_pkg::*;

    localparam int n_banks = 2 ** $bits(bank_t);

    logic [n_banks-1:0] open_q;
    row_t               row_q [n_banks];

    always_comb begin
        if (!open_q[lookup_bank]) begin
            bank_state = bank_closed;
        end else if (row_q[lookup_bank] == lookup_row) begin
            bank_state = bank_row_hit;
        end else begin
            bank_state = bank_row_conflict;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            open_q <= '0;
        end else begin
            if (close_en) begin
                if (close_all) begin
                    open_q <= '0;
                end else begin
                    open_q[close_bank] <= 1'b0;
                end
            end
            if (open_en) begin
                open_q[open_bank] <= 1'b1;
            end
        end
    end

    // row only means something while its open flag is set
    always_ff @(posedge clk) begin
        if (open_en) begin
            row_q[open_bank] <= open_row;
        end
    end

endmodule

// ==== design/cpu_front.sv ====
`timescale 1ns/1ns

module cpu_front (
    input  logic                 clk,
    input  logic                 rst,
    input  sdram_pkg::mem_req_t  cpu_req,
    input  logic                 cpu_in_valid,
    output logic                 cpu_busy,
    output logic                 cpu_out_valid,
    output sdram_pkg::word_t     cpu_rdata,
    output sdram_pkg::mem_req_t  mem_req,
    output logic                 req_valid,
    input  logic                 ctrl_ready,
    input  logic                 rsp_valid,
    input  sdram_pkg::word_t     rsp_data
);
    import sdram_pkg::*;

    localparam int idx_w = $clog2(prefetch_depth + 1);

    typedef enum logic [1:0] {
        fe_idle,
        fe_hit,
        fe_write,
        fe_miss
    } fe_state_e;

    fe_state_e state_q;
    mem_req_t  req_q;
    addr_t     pf_addr [prefetch_depth];
    word_t     pf_data [prefetch_depth];
    logic [prefetch_depth-1:0] pf_valid, pf_pend, valid_d, pend_d, addr_match;
    logic [idx_w-1:0] hit_idx, hit_q, beat_cnt;
    logic accept, hit, first_beat;

    assign accept     = cpu_in_valid && !cpu_busy;
    assign first_beat = rsp_valid && beat_cnt == '0;
    assign mem_req    = req_q;

    // buffer lookup on the incoming address
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < prefetch_depth; i++) begin
            addr_match[i] = pf_addr[i] == cpu_req.addr;
            if (addr_match[i] && pf_valid[i]) begin
                hit     = 1'b1;
                hit_idx = idx_w'(i);
            end
        end
    end

    // pend marks an entry still waiting for its beat
    // a write kills both, so a late beat cannot revive it
    always_comb begin
        valid_d = pf_valid;
        pend_d  = pf_pend;
        if (rsp_valid) begin
            if (beat_cnt == '0) begin
                valid_d = '0;
                pend_d  = '1;
            end else begin
                valid_d[beat_cnt - 1] = pf_pend[beat_cnt - 1];
            end
        end
        if (accept && cpu_req.write) begin
            valid_d &= ~addr_match;
            pend_d  &= ~addr_match;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= fe_idle;
            cpu_busy      <= 1'b0;
            cpu_out_valid <= 1'b0;
            req_valid     <= 1'b0;
            beat_cnt      <= '0;
            pf_valid      <= '0;
            pf_pend       <= '0;
        end else begin
            cpu_out_valid <= 1'b0;
            pf_valid      <= valid_d;
            pf_pend       <= pend_d;
            if (rsp_valid) begin
                beat_cnt <= (beat_cnt == idx_w'(prefetch_depth)) ? '0 : beat_cnt + 1'b1;
            end
            case (state_q)
                fe_idle: begin
                    if (accept) begin
                        cpu_busy <= 1'b1;
                        if (cpu_req.write) begin
                            req_valid <= 1'b1;
                            state_q   <= fe_write;
                        end else if (hit) begin
                            state_q <= fe_hit;
                        end else begin
                            req_valid <= 1'b1;
                            state_q   <= fe_miss;
                        end
                    end
                end
                fe_hit: begin
                    cpu_out_valid <= 1'b1;
                    cpu_busy      <= 1'b0;
                    state_q       <= fe_idle;
                end
                fe_write: begin
                    if (ctrl_ready) begin
                        req_valid <= 1'b0;
                        cpu_busy  <= 1'b0;
                        state_q   <= fe_idle;
                    end
                end
                default: begin
                    if (ctrl_ready) begin
                        req_valid <= 1'b0;
                    end
                    if (first_beat) begin
                        cpu_out_valid <= 1'b1;
                        cpu_busy      <= 1'b0;
                        state_q       <= fe_idle;
                    end
                end
            endcase
        end
    end

    // payload side of the buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= cpu_req;
            hit_q <= hit_idx;
        end
        if (first_beat) begin
            for (int i = 0; i < prefetch_depth; i++) begin
                pf_addr[i] <= step_addr(req_q.addr, req_q.step, i + 1);
            end
        end else if (rsp_valid) begin
            pf_data[beat_cnt - 1] <= rsp_data;
        end
        if (state_q == fe_hit) begin
            cpu_rdata <= pf_data[hit_q];
        end else if (state_q == fe_miss && first_beat) begin
            cpu_rdata <= rsp_data;
        end
    end

endmodule

// ==== design/sdram_cmd_engine.sv ====
`timescale 1ns/1ns

module sdram_cmd_engine #(
    parameter int refresh_interval = 750
) (
    input  logic                    clk,
    input  logic                    rst,
    input  sdram_pkg::mem_req_t     mem_req,
    input  logic                    req_valid,
    output logic                    ctrl_ready,
    output logic                    rsp_valid,
    output sdram_pkg::word_t        rsp_data,
    output sdram_pkg::bank_t        lookup_bank,
    output sdram_pkg::row_t         lookup_row,
    input  sdram_pkg::bank_state_e  bank_state,
    output logic                    open_en,
    output sdram_pkg::bank_t        open_bank,
    output sdram_pkg::row_t         open_row,
    output logic                    close_en,
    output logic                    close_all,
    output sdram_pkg::bank_t        close_bank,
    output sdram_pkg::sdram_pins_t  sdram_pins,
    output sdram_pkg::word_t        dq_out,
    output logic                    dq_oe,
    input  sdram_pkg::word_t        dq_in
);
    import sdram_pkg::*;

    localparam int ref_w = $clog2(refresh_interval + 1);
    localparam int idx_w = $clog2(prefetch_depth + 1);
    localparam sdram_pins_t pins_nop = '{cke: 1'b1, cmd: cmd_nop, dqm: 1'b0, ba: '0, a: '0};

    typedef enum logic [2:0] {
        st_idle,
        st_precharge,
        st_activate,
        st_wait,
        st_col,
        st_drain,
        st_refresh
    } state_e;

    state_e           state_q, state_d, after_q, after_d;
    logic [2:0]       wait_q, wait_d;
    logic [idx_w-1:0] rd_idx_q, rd_idx_d;
    logic             pre_all_q, pre_all_d;
    mem_req_t         held_q, cur_q;
    logic             held_v, start;
    logic [ref_w-1:0] ref_cnt;
    logic             ref_due, ref_take;
    sdram_pins_t      pins_d;
    logic             dq_oe_d;
    word_t            dq_q;
    logic [cas_latency:0] rd_pipe;

    ////////////////////////////////////////////////////////////
    // one-deep request slot and tracker hookup
    ////////////////////////////////////////////////////////////

    assign ctrl_ready  = !held_v;
    assign lookup_bank = addr_bank(held_q.addr);
    assign lookup_row  = addr_row(held_q.addr);
    assign open_bank   = addr_bank(cur_q.addr);
    assign open_row    = addr_row(cur_q.addr);
    assign close_all   = pre_all_q;
    assign close_bank  = addr_bank(cur_q.addr);

    // beats line up with the read pipe, cas_latency + 1 after the pin
    assign rsp_valid = rd_pipe[cas_latency];
    assign rsp_data  = dq_q;

    ////////////////////////////////////////////////////////////
    // command sequencing
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d   = state_q;
        after_d   = after_q;
        wait_d    = wait_q;
        rd_idx_d  = rd_idx_q;
        pre_all_d = pre_all_q;
        start     = 1'b0;
        ref_take  = 1'b0;
        open_en   = 1'b0;
        close_en  = 1'b0;
        dq_oe_d   = 1'b0;
        pins_d    = pins_nop;
        case (state_q)
            st_idle: begin
                rd_idx_d = '0;
                // refresh wins over a waiting request
                if (ref_due) begin
                    ref_take  = 1'b1;
                    pre_all_d = 1'b1;
                    after_d   = st_refresh;
                    state_d   = st_precharge;
                end else if (held_v) begin
                    start     = 1'b1;
                    pre_all_d = 1'b0;
                    case (bank_state)
                        bank_row_hit: state_d = st_col;
                        bank_row_conflict: begin
                            after_d = st_activate;
                            state_d = st_precharge;
                        end
                        default: state_d = st_activate;
                    endcase
                end
            end
            st_precharge: begin
                pins_d.cmd   = cmd_precharge;
                pins_d.ba    = addr_bank(cur_q.addr);
                pins_d.a[10] = pre_all_q;
                close_en     = 1'b1;
                wait_d       = 3'(t_rp - 2);
                state_d      = st_wait;
            end
            st_activate: begin
                pins_d.cmd = cmd_active;
                pins_d.ba  = addr_bank(cur_q.addr);
                pins_d.a   = addr_row(cur_q.addr);
                open_en    = 1'b1;
                wait_d     = 3'(t_rcd - 2);
                after_d    = st_col;
                state_d    = st_wait;
            end
            st_wait: begin
                if (wait_q == '0) begin
                    state_d = after_q;
                end else begin
                    wait_d = wait_q - 1'b1;
                end
            end
            st_col: begin
                pins_d.ba = addr_bank(cur_q.addr);
                pins_d.a  = {7'b0, step_col(addr_col(cur_q.addr), cur_q.step, rd_idx_q)};
                if (cur_q.write) begin
                    pins_d.cmd = cmd_write;
                    dq_oe_d    = 1'b1;
                    state_d    = st_idle;
                end else begin
                    // back-to-back reads, one per cycle
                    pins_d.cmd = cmd_read;
                    rd_idx_d   = rd_idx_q + 1'b1;
                    if (rd_idx_q == idx_w'(prefetch_depth)) begin
                        state_d = st_drain;
                    end
                end
            end
            st_drain: begin
                // leave on the last beat
                if (rd_pipe[cas_latency] && rd_pipe[cas_latency-1:0] == '0) begin
                    state_d = st_idle;
                end
            end
            st_refresh: begin
                pins_d.cmd = cmd_refresh;
                wait_d     = 3'(t_rfc - 2);
                after_d    = st_idle;
                state_d    = st_wait;
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= st_idle;
            after_q    <= st_idle;
            wait_q     <= '0;
            rd_idx_q   <= '0;
            pre_all_q  <= 1'b0;
            held_v     <= 1'b0;
            sdram_pins <= pins_nop;
            dq_oe      <= 1'b0;
            rd_pipe    <= '0;
        end else begin
            state_q    <= state_d;
            after_q    <= after_d;
            wait_q     <= wait_d;
            rd_idx_q   <= rd_idx_d;
            pre_all_q  <= pre_all_d;
            sdram_pins <= pins_d;
            dq_oe      <= dq_oe_d;
            rd_pipe    <= {rd_pipe[cas_latency-1:0], sdram_pins.cmd == cmd_read};
            if (req_valid && ctrl_ready) begin
                held_v <= 1'b1;
            end else if (start) begin
                held_v <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        dq_q <= dq_in;
        if (req_valid && ctrl_ready) begin
            held_q <= mem_req;
        end
        if (start) begin
            cur_q <= held_q;
        end
        if (dq_oe_d) begin
            dq_out <= cur_q.wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // refresh timer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ref_cnt <= '0;
            ref_due <= 1'b0;
        end else begin
            if (ref_take) begin
                ref_due <= 1'b0;
            end
            if (ref_cnt == ref_w'(refresh_interval - 1)) begin
                ref_cnt <= '0;
                ref_due <= 1'b1;
            end else begin
                ref_cnt <= ref_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== design/sdram_pkg.sv ====
package sdram_pkg;

    ////////////////////////////////////////////////////////////
    // widths and address fields
    ////////////////////////////////////////////////////////////

    localparam int addr_w = 23;
    localparam int data_w = 32;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] word_t;
    typedef logic [12:0]       row_t;
    typedef logic [1:0]        bank_t;
    typedef logic [5:0]        col_t;

    // row 22:10, bank 9:8, column word 7:2
    function automatic row_t addr_row(addr_t addr);
        return addr[22:10];
    endfunction

    function automatic bank_t addr_bank(addr_t addr);
        return addr[9:8];
    endfunction

    function automatic col_t addr_col(addr_t addr);
        return addr[7:2];
    endfunction

    // column n steps on from base, wraps inside the row
    function automatic col_t step_col(col_t base, logic step, int unsigned n);
        return base + col_t'(step ? n * 4 : n);
    endfunction

    function automatic addr_t step_addr(addr_t base, logic step, int unsigned n);
        return {base[22:8], step_col(addr_col(base), step, n), 2'b00};
    endfunction

    ////////////////////////////////////////////////////////////
    // timing and burst shape
    ////////////////////////////////////////////////////////////

    localparam int prefetch_depth = 3;
    localparam int cas_latency    = 3;
    localparam int t_rp           = 3;
    localparam int t_rcd          = 3;
    localparam int t_rfc          = 7;

    ////////////////////////////////////////////////////////////
    // commands and bundles
    ////////////////////////////////////////////////////////////

    // {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        cmd_deselect  = 4'b1000,
        cmd_nop       = 4'b0111,
        cmd_active    = 4'b0011,
        cmd_read      = 4'b0101,
        cmd_write     = 4'b0100,
        cmd_precharge = 4'b0010,
        cmd_refresh   = 4'b0001
    } sdram_cmd_e;

    typedef struct packed {
        logic       cke;
        sdram_cmd_e cmd;
        logic       dqm;
        bank_t      ba;
        logic [12:0] a;
    } sdram_pins_t;

    typedef struct packed {
        addr_t addr;
        logic  write;
        word_t wdata;
        logic  step;
    } mem_req_t;

    typedef enum logic [1:0] {
        bank_closed,
        bank_row_hit,
        bank_row_conflict
    } bank_state_e;

endpackage

// ==== design/sdram_prefetch_top.sv ====
`timescale 1ns/1ns

module sdram_prefetch_top #(
    parameter int refresh_interval = 750
) (
    input  logic                    clk,
    input  logic                    rst,
    input  sdram_pkg::mem_req_t     cpu_req,
    input  logic                    cpu_in_valid,
    output logic                    cpu_busy,
    output logic                    cpu_out_valid,
    output sdram_pkg::word_t        cpu_rdata,
    output sdram_pkg::sdram_pins_t  sdram_pins,
    output sdram_pkg::word_t        dq_out,
    output logic                    dq_oe,
    input  sdram_pkg::word_t        dq_in
);
    import sdram_pkg::*;

    // front end to controller
    mem_req_t mem_req;
    logic     req_valid;
    logic     ctrl_ready;
    logic     rsp_valid;
    word_t    rsp_data;

    // controller to open-row table
    bank_t       lookup_bank, open_bank, close_bank;
    row_t        lookup_row, open_row;
    bank_state_e bank_state;
    logic        open_en, close_en, close_all;

    cpu_front i_cpu_front (
        .clk           (clk),
        .rst           (rst),
        .cpu_req       (cpu_req),
        .cpu_in_valid  (cpu_in_valid),
        .cpu_busy      (cpu_busy),
        .cpu_out_valid (cpu_out_valid),
        .cpu_rdata     (cpu_rdata),
        .mem_req       (mem_req),
        .req_valid     (req_valid),
        .ctrl_ready    (ctrl_ready),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data)
    );

    bank_tracker i_bank_tracker (
        .clk         (clk),
        .rst         (rst),
        .lookup_bank (lookup_bank),
        .lookup_row  (lookup_row),
        .bank_state  (bank_state),
        .open_en     (open_en),
        .open_bank   (open_bank),
        .open_row    (open_row),
        .close_en    (close_en),
        .close_all   (close_all),
        .close_bank  (close_bank)
    );

    sdram_cmd_engine #(
        .refresh_interval (refresh_interval)
    ) i_sdram_cmd_engine (
        .clk         (clk),
        .rst         (rst),
        .mem_req     (mem_req),
        .req_valid   (req_valid),
        .ctrl_ready  (ctrl_ready),
        .rsp_valid   (rsp_valid),
        .rsp_data    (rsp_data),
        .lookup_bank (lookup_bank),
        .lookup_row  (lookup_row),
        .bank_state  (bank_state),
        .open_en     (open_en),
        .open_bank   (open_bank),
        .open_row    (open_row),
        .close_en    (close_en),
        .close_all   (close_all),
        .close_bank  (close_bank),
        .sdram_pins  (sdram_pins),
        .dq_out      (dq_out),
        .dq_oe       (dq_oe),
        .dq_in       (dq_in)
    );

endmodule

// ==== dv/sdram_model.sv ====
`timescale 1ns/1ns

module sdram_model (
    input  logic                   clk,
    input  sdram_pkg::sdram_pins_t sdram_pins,
    input  sdram_pkg::word_t       dq_out,
    input  logic                   dq_oe,
    output sdram_pkg::word_t       dq_in
);
    import sdram_pkg::*;

    localparam int pipe_len = cas_latency - 1;

    typedef logic [20:0] word_addr_t;

    // words never written read back as zero
    word_t                mem [word_addr_t];
    row_t                 row_open [4] = '{default: '0};
    logic [3:0]           bank_open = '0;
    word_addr_t           rd_addr [pipe_len];
    logic [pipe_len-1:0]  rd_v = '0;
    logic [pipe_len-1:0]  rd_ok = '0;
    word_t                dq_q = '0;

    assign dq_in = dq_q;

    // {row, bank, column word}
    function automatic word_addr_t word_addr(bank_t ba, logic [12:0] a);
        return {row_open[ba], ba, a[5:0]};
    endfunction

    always @(posedge clk) begin
        if (sdram_pins.cmd == cmd_active) begin
            row_open[sdram_pins.ba]  = sdram_pins.a;
            bank_open[sdram_pins.ba] = 1'b1;
        end
        // a10 selects all banks
        if (sdram_pins.cmd == cmd_precharge) begin
            if (sdram_pins.a[10]) begin
                bank_open = '0;
            end else begin
                bank_open[sdram_pins.ba] = 1'b0;
            end
        end
        if (sdram_pins.cmd == cmd_refresh) begin
            bank_open = '0;
        end
        // column commands to a closed bank store nothing
        if (sdram_pins.cmd == cmd_write && dq_oe && bank_open[sdram_pins.ba]) begin
            mem[word_addr(sdram_pins.ba, sdram_pins.a)] = dq_out;
        end
        // read data leaves cas_latency edges after the command edge
        rd_v       <= {rd_v[pipe_len-2:0], sdram_pins.cmd == cmd_read};
        rd_ok      <= {rd_ok[pipe_len-2:0], bank_open[sdram_pins.ba]};
        rd_addr[0] <= word_addr(sdram_pins.ba, sdram_pins.a);
        for (int i = 1; i < pipe_len; i++) begin
            rd_addr[i] <= rd_addr[i-1];
        end
        dq_q <= '0;
        if (rd_v[pipe_len-1]) begin
            // closed bank drives unknown data
            if (!rd_ok[pipe_len-1]) begin
                dq_q <= 'x;
            end else if (mem.exists(rd_addr[pipe_len-1])) begin
                dq_q <= mem[rd_addr[pipe_len-1]];
            end
        end
    end

endmodule

// ==== dv/sdram_properties.sv ====
`timescale 1ns/1ns

module sdram_properties (
    input logic                   clk,
    input logic                   rst,
    input logic                   cpu_in_valid,
    input logic                   cpu_busy,
    input logic                   cpu_out_valid,
    input sdram_pkg::sdram_pins_t sdram_pins,
    input logic                   dq_oe
);
    import sdram_pkg::*;

    logic        is_active;
    logic        is_rw;
    int unsigned fail_cnt = 0;

    assign is_active = sdram_pins.cmd == cmd_active;
    assign is_rw     = sdram_pins.cmd == cmd_read || sdram_pins.cmd == cmd_write;

    a_out_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        cpu_out_valid |=> !cpu_out_valid)
        else begin
            fail_cnt++;
            $error("cpu_out_valid high two cycles running");
        end

    a_dq_oe_write: assert property (@(posedge clk) disable iff (rst)
        dq_oe |-> sdram_pins.cmd == cmd_write)
        else begin
            fail_cnt++;
            $error("dq_oe high without a write command");
        end

    // activate to column command spacing
    a_rcd: assert property (@(posedge clk) disable iff (rst)
        is_active |=> !is_rw [*(t_rcd - 1)])
        else begin
            fail_cnt++;
            $error("read or write within t_rcd after activate");
        end

    a_no_req_when_busy: assert property (@(posedge clk) disable iff (rst)
        cpu_in_valid |-> !cpu_busy)
        else begin
            fail_cnt++;
            $error("cpu_in_valid raised while cpu_busy");
        end

endmodule

bind sdram_prefetch_top sdram_properties i_sdram_properties (
    .clk           (clk),
    .rst           (rst),
    .cpu_in_valid  (cpu_in_valid),
    .cpu_busy      (cpu_busy),
    .cpu_out_valid (cpu_out_valid),
    .sdram_pins    (sdram_pins),
    .dq_oe         (dq_oe)
);

// ==== dv/sdram_stimulus.txt ====
# op (W write, R read), byte address, write data or expected read data, step
# step 0 prefetches the next three words, step 1 every fourth word in the row
W 000100 a1b2c3d4 0
R 000100 a1b2c3d4 0
W 000204 11110001 0
W 00020c 11110003 0
R 000200 00000000 0
R 000204 11110001 0
R 000208 00000000 0
R 00020c 11110003 0
W 000208 22220002 0
R 000208 22220002 0
W 000310 33330001 0
W 000330 33330003 0
R 000300 00000000 1
R 000310 33330001 0
R 000330 33330003 0
R 0003e0 00000000 1
R 000310 33330001 0
W 000500 55550001 0
R 000100 a1b2c3d4 0
R 000500 55550001 0
W 7ffc00 deadbeef 0
R 7ffc00 deadbeef 0

// ==== dv/sdram_tb.sv ====
`timescale 1ns/1ns

module sdram_tb;
    import sdram_pkg::*;

    localparam int reset_cycles  = 16;
    localparam int cycles_per_op = 300;

    logic        clk = 1'b0;
    logic        rst;
    mem_req_t    cpu_req;
    logic        cpu_in_valid;
    logic        cpu_busy;
    logic        cpu_out_valid;
    word_t       cpu_rdata;
    sdram_pins_t sdram_pins;
    word_t       dq_out;
    logic        dq_oe;
    word_t       dq_in;

    // for reads, wdata carries the expected word
    mem_req_t    ops [$];
    bit          loaded = 1'b0;
    int          err_cnt = 0;
    int          read_cnt = 0;
    int          ref_cnt = 0;
    int          settle = 0;
    logic [31:0] rnd_state = 32'h0f52ee6a;

    // expected prefetch buffer contents
    addr_t       exp_addr [prefetch_depth];
    logic        exp_valid [prefetch_depth];

    always #4 clk = ~clk;

    sdram_prefetch_top #(
        .refresh_interval (120)
    ) i_dut (
        .clk           (clk),
        .rst           (rst),
        .cpu_req       (cpu_req),
        .cpu_in_valid  (cpu_in_valid),
        .cpu_busy      (cpu_busy),
        .cpu_out_valid (cpu_out_valid),
        .cpu_rdata     (cpu_rdata),
        .sdram_pins    (sdram_pins),
        .dq_out        (dq_out),
        .dq_oe         (dq_oe),
        .dq_in         (dq_in)
    );

    sdram_model i_sdram_model (
        .clk        (clk),
        .sdram_pins (sdram_pins),
        .dq_out     (dq_out),
        .dq_oe      (dq_oe),
        .dq_in      (dq_in)
    );

    // command counters, pins as seen before each edge
    always @(posedge clk) begin
        if (rst) begin
            read_cnt <= 0;
            ref_cnt  <= 0;
        end else begin
            if (sdram_pins.cmd == cmd_read) begin
                read_cnt <= read_cnt + 1;
            end
            if (sdram_pins.cmd == cmd_refresh) begin
                ref_cnt <= ref_cnt + 1;
            end
        end
    end

    always @(negedge clk) begin
        if (i_dut.i_sdram_properties.fail_cnt != 0) begin
            $display("a concurrent assertion on the DUT failed");
            $display("*** TEST FAILED ***");
            $fatal(1, "assertion failure");
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // same row and bank, column wraps at 64 words
    function automatic addr_t prefetch_addr(addr_t base, logic step, int n);
        logic [5:0] col;
        col = base[7:2] + 6'(step ? 4 * n : n);
        return {base[22:8], col, 2'b00};
    endfunction

    function automatic logic expect_hit(addr_t a);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < prefetch_depth; i++) begin
            if (exp_valid[i] && exp_addr[i] == a) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic load_ops();
        int          fd;
        int          c;
        int          n;
        byte         op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] s;
        mem_req_t    r;
        fd = $fopen("dv/sdram_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/sdram_stimulus.txt");
            $display("*** TEST FAILED ***");
            $fatal(1, "no stimulus");
        end
        n = $fscanf(fd, " %c", op);
        while (n == 1) begin
            if (op == "#") begin
                c = $fgetc(fd);
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);
                end
            end else begin
                n = $fscanf(fd, " %h %h %h", a, d, s);
                if (n != 3 || (op != "W" && op != "R")) begin
                    $display("stimulus line after operation %0d is malformed", ops.size());
                    $display("*** TEST FAILED ***");
                    $fatal(1, "bad stimulus");
                end
                r.addr  = addr_t'(a);
                r.write = op == "W";
                r.wdata = d;
                r.step  = s[0];
                ops.push_back(r);
            end
            n = $fscanf(fd, " %c", op);
        end
        $fclose(fd);
        if (ops.size() == 0) begin
            $display("stimulus file holds no operations");
            $display("*** TEST FAILED ***");
            $fatal(1, "empty stimulus");
        end
    endtask

    task automatic run_op(input mem_req_t op);
        int   gap;
        int   lat;
        int   reads_before;
        logic hit;
        rnd_state = xorshift32(rnd_state);
        gap       = int'(rnd_state[2:0]) + settle;
        settle    = 0;
        repeat (gap) @(negedge clk);
        while (cpu_busy) @(negedge clk);
        hit           = expect_hit(op.addr);
        reads_before  = read_cnt;
        cpu_req       = op;
        cpu_req.wdata = op.write ? op.wdata : '0;
        cpu_in_valid  = 1'b1;
        @(negedge clk);
        cpu_in_valid = 1'b0;
        lat          = 1;
        check_value("cpu_busy", cpu_busy, 1'b1);
        if (op.write) begin
            while (cpu_busy) begin
                check_value("cpu_out_valid", cpu_out_valid, 1'b0);
                @(negedge clk);
            end
            for (int i = 0; i < prefetch_depth; i++) begin
                if (exp_addr[i] == op.addr) begin
                    exp_valid[i] = 1'b0;
                end
            end
        end else begin
            while (!cpu_out_valid) begin
                @(negedge clk);
                lat++;
            end
            check_value("cpu_rdata", cpu_rdata, op.wdata);
            check_value("cpu_busy", cpu_busy, 1'b0);
            if (hit) begin
                check_value("hit_latency", lat, 2);
                check_value("read_cmds", read_cnt - reads_before, 0);
            end else begin
                check_value("read_cmds", read_cnt - reads_before, prefetch_depth + 1);
                for (int i = 0; i < prefetch_depth; i++) begin
                    exp_addr[i]  = prefetch_addr(op.addr, op.step, i + 1);
                    exp_valid[i] = 1'b1;
                end
                // remaining beats still on their way into the buffer
                settle = prefetch_depth + 1;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        rst          = 1'b1;
        cpu_in_valid = 1'b0;
        cpu_req      = '0;
        for (int i = 0; i < prefetch_depth; i++) begin
            exp_addr[i]  = '0;
            exp_valid[i] = 1'b0;
        end
        load_ops();
        loaded = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        foreach (ops[i]) begin
            run_op(ops[i]);
        end
        // run spans several refresh intervals
        check_value("refresh_seen", ref_cnt != 0, 1'b1);
        if (err_cnt == 0 && i_dut.i_sdram_properties.fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "run ended with failures");
        end
    end

    initial begin
        wait (loaded);
        repeat (ops.size() * cycles_per_op + reset_cycles) @(posedge clk);
        $display("timeout, %0d operations did not complete in time", ops.size());
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== sdram_prefetch.f ====
design/sdram_pkg.sv
design/cpu_front.sv
design/bank_tracker.sv
design/sdram_cmd_engine.sv
design/sdram_prefetch_top.sv
dv/sdram_model.sv
dv/sdram_properties.sv
dv/sdram_tb.sv
